/* common/memmap_pkg.sv */
`default_nettype none

package memmap_pkg;

  //////////////////////////////////////////////////////////////////////
  // core port widths
  //////////////////////////////////////////////////////////////////////

  // byte address width of the core port
  localparam int unsigned AW = 32;

  // data word width, the banks store whole words of this size
  localparam int unsigned DW = 32;

  // one byte enable per byte lane of a data word
  localparam int unsigned BW = DW / 8;

  //////////////////////////////////////////////////////////////////////
  // response opcodes
  //////////////////////////////////////////////////////////////////////

  // a mapped request that a bank has served
  localparam logic OPC_OK = 1'b0;

  // the address hit no region and was answered by the demultiplexer
  localparam logic OPC_ERR = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // width of an index that picks one of n regions
  // a single region still gets a one bit index
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

/* design/req_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module req_slice (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  // core side
  input  logic                      req_i,
  input  logic [memmap_pkg::AW-1:0] add_i,
  input  logic                      wen_i,
  input  logic [memmap_pkg::DW-1:0] data_i,
  input  logic [memmap_pkg::BW-1:0] be_i,
  output logic                      gnt_o,
  // downstream side
  output logic                      req_o,
  output logic [memmap_pkg::AW-1:0] add_o,
  output logic                      wen_o,
  output logic [memmap_pkg::DW-1:0] data_o,
  output logic [memmap_pkg::BW-1:0] be_o,
  input  logic                      gnt_i
);
  import memmap_pkg::*;

  logic          full_q;
  logic          load;
  logic [AW-1:0] add_q;
  logic          wen_q;
  logic [DW-1:0] data_q;
  logic [BW-1:0] be_q;

  // the slot is free when empty or when the held request leaves this cycle
  // a clear pulse refuses new requests since it empties the slot
  assign gnt_o = ~clear_i & (~full_q | gnt_i);
  assign load  = req_i & gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (clear_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (req_o && gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      add_q  <= add_i;
      wen_q  <= wen_i;
      data_q <= data_i;
      be_q   <= be_i;
    end
  end

  assign req_o  = full_q;
  assign add_o  = add_q;
  assign wen_o  = wen_q;
  assign data_o = data_q;
  assign be_o   = be_q;

endmodule

`default_nettype wire

/* memmap_demux/memmap_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_demux #(
  parameter int unsigned NB_REGION = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clear_i,
  input  logic [NB_REGION-1:0][memmap_pkg::AW-1:0] region_start_addr_i,
  input  logic [NB_REGION-1:0][memmap_pkg::AW-1:0] region_end_addr_i,
  // target side
  input  logic                                     req_i,
  input  logic [memmap_pkg::AW-1:0]                add_i,
  input  logic                                     wen_i,
  input  logic [memmap_pkg::DW-1:0]                data_i,
  input  logic [memmap_pkg::BW-1:0]                be_i,
  output logic                                     gnt_o,
  output logic                                     r_valid_o,
  output logic [memmap_pkg::DW-1:0]                r_data_o,
  output logic                                     r_opc_o,
  input  logic                                     r_ready_i,
  // bank side
  output logic [NB_REGION-1:0]                     bank_req_o,
  output logic [NB_REGION-1:0][memmap_pkg::AW-1:0] bank_add_o,
  output logic [NB_REGION-1:0]                     bank_wen_o,
  output logic [NB_REGION-1:0][memmap_pkg::DW-1:0] bank_data_o,
  output logic [NB_REGION-1:0][memmap_pkg::BW-1:0] bank_be_o,
  input  logic [NB_REGION-1:0]                     bank_gnt_i,
  input  logic [NB_REGION-1:0]                     bank_r_valid_i,
  input  logic [NB_REGION-1:0][memmap_pkg::DW-1:0] bank_r_data_i,
  output logic [NB_REGION-1:0]                     bank_r_ready_o
);
  import memmap_pkg::*;

  localparam int unsigned IDX_W = idx_width(NB_REGION);

  logic             hit;
  logic [IDX_W-1:0] sel;
  logic             r_done;
  logic             route_ok;
  logic             accept;
  logic             pending_q;
  logic             owner_err_q;
  logic [IDX_W-1:0] owner_q;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // later regions overwrite earlier ones, so the highest match wins
  always_comb begin : decode
    hit = 1'b0;
    sel = '0;
    for (int unsigned i = 0; i < NB_REGION; i++) begin
      if ((add_i >= region_start_addr_i[i]) && (add_i < region_end_addr_i[i])) begin
        hit = 1'b1;
        sel = IDX_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request routing
  //////////////////////////////////////////////////////////////////////

  assign r_done = r_valid_o & r_ready_i;

  // only one response may be outstanding, which keeps responses in order
  assign route_ok = ~clear_i & (~pending_q | r_done);

  // an unmapped request is taken here without asking any bank
  assign gnt_o  = route_ok & (hit ? bank_gnt_i[sel] : 1'b1);
  assign accept = req_i & gnt_o;

  for (genvar ii = 0; ii < NB_REGION; ii++) begin : gen_bank
    assign bank_req_o[ii]  = req_i & route_ok & hit & (sel == IDX_W'(ii));
    assign bank_add_o[ii]  = add_i - region_start_addr_i[ii];
    assign bank_wen_o[ii]  = wen_i;
    assign bank_data_o[ii] = data_i;
    assign bank_be_o[ii]   = be_i;
    // a clear also drains whatever response a bank still holds
    assign bank_r_ready_o[ii] = clear_i |
        (r_ready_i & pending_q & ~owner_err_q & (owner_q == IDX_W'(ii)));
  end

  //////////////////////////////////////////////////////////////////////
  // pending response owner
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      owner_err_q <= 1'b0;
      owner_q     <= '0;
    end else if (clear_i) begin
      pending_q   <= 1'b0;
      owner_err_q <= 1'b0;
      owner_q     <= '0;
    end else if (accept) begin
      pending_q   <= 1'b1;
      owner_err_q <= ~hit;
      owner_q     <= sel;
    end else if (r_done) begin
      pending_q   <= 1'b0;
    end
  end

  // the error path answers with zero data as soon as it owns the response
  always_comb begin : resp_sel
    r_valid_o = 1'b0;
    r_data_o  = '0;
    r_opc_o   = OPC_OK;
    if (pending_q) begin
      if (owner_err_q) begin
        r_valid_o = 1'b1;
        r_opc_o   = OPC_ERR;
      end else begin
        r_valid_o = bank_r_valid_i[owner_q];
        r_data_o  = bank_r_data_i[owner_q];
      end
    end
  end

endmodule

`default_nettype wire

/* design/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
  parameter int unsigned DEPTH = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic [memmap_pkg::AW-1:0] add_i,
  input  logic                      wen_i,
  input  logic [memmap_pkg::DW-1:0] data_i,
  input  logic [memmap_pkg::BW-1:0] be_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output logic [memmap_pkg::DW-1:0] r_data_o,
  input  logic                      r_ready_i
);
  import memmap_pkg::*;

  // DEPTH is a power of two, so dropping the upper offset bits wraps it
  localparam int unsigned IW = $clog2(DEPTH);

  logic [DW-1:0] mem_q [DEPTH];
  logic [IW-1:0] idx;
  logic          access;
  logic          r_valid_q;
  logic [DW-1:0] r_data_q;

  // byte offset to word index
  assign idx = add_i[IW+1:2];

  // a new access fits when the response slot is free or being emptied
  assign gnt_o  = ~r_valid_q | r_ready_i;
  assign access = req_i & gnt_o;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // wen low means write, only the enabled byte lanes change
  always_ff @(posedge clk_i) begin
    if (access && !wen_i) begin
      for (int unsigned b = 0; b < BW; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // held response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (access) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // reads return the word as it was before this cycle, writes return zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      r_data_q <= wen_i ? mem_q[idx] : '0;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

`default_nettype wire

/* design/memmap_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_top #(
  parameter int unsigned NB_REGION   = 2,
  parameter int unsigned BANK0_WORDS = 64,
  parameter int unsigned BANK1_WORDS = 32
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clear_i,
  input  logic [NB_REGION-1:0][memmap_pkg::AW-1:0] region_start_addr_i,
  input  logic [NB_REGION-1:0][memmap_pkg::AW-1:0] region_end_addr_i,
  input  logic                                     req_i,
  input  logic [memmap_pkg::AW-1:0]                add_i,
  input  logic                                     wen_i,
  input  logic [memmap_pkg::DW-1:0]                data_i,
  input  logic [memmap_pkg::BW-1:0]                be_i,
  output logic                                     gnt_o,
  output logic                                     r_valid_o,
  output logic [memmap_pkg::DW-1:0]                r_data_o,
  output logic                                     r_opc_o,
  input  logic                                     r_ready_i
);
  import memmap_pkg::*;

  // registered request from the slice
  logic          s_req;
  logic [AW-1:0] s_add;
  logic          s_wen;
  logic [DW-1:0] s_data;
  logic [BW-1:0] s_be;
  logic          s_gnt;

  // per bank request and response
  logic [NB_REGION-1:0]         bank_req;
  logic [NB_REGION-1:0][AW-1:0] bank_add;
  logic [NB_REGION-1:0]         bank_wen;
  logic [NB_REGION-1:0][DW-1:0] bank_data;
  logic [NB_REGION-1:0][BW-1:0] bank_be;
  logic [NB_REGION-1:0]         bank_gnt;
  logic [NB_REGION-1:0]         bank_r_valid;
  logic [NB_REGION-1:0][DW-1:0] bank_r_data;
  logic [NB_REGION-1:0]         bank_r_ready;

  req_slice req_slice_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .req_i   (req_i),
    .add_i   (add_i),
    .wen_i   (wen_i),
    .data_i  (data_i),
    .be_i    (be_i),
    .gnt_o   (gnt_o),
    .req_o   (s_req),
    .add_o   (s_add),
    .wen_o   (s_wen),
    .data_o  (s_data),
    .be_o    (s_be),
    .gnt_i   (s_gnt)
  );

  memmap_demux #(
    .NB_REGION (NB_REGION)
  ) memmap_demux_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .clear_i             (clear_i),
    .region_start_addr_i (region_start_addr_i),
    .region_end_addr_i   (region_end_addr_i),
    .req_i               (s_req),
    .add_i               (s_add),
    .wen_i               (s_wen),
    .data_i              (s_data),
    .be_i                (s_be),
    .gnt_o               (s_gnt),
    .r_valid_o           (r_valid_o),
    .r_data_o            (r_data_o),
    .r_opc_o             (r_opc_o),
    .r_ready_i           (r_ready_i),
    .bank_req_o          (bank_req),
    .bank_add_o          (bank_add),
    .bank_wen_o          (bank_wen),
    .bank_data_o         (bank_data),
    .bank_be_o           (bank_be),
    .bank_gnt_i          (bank_gnt),
    .bank_r_valid_i      (bank_r_valid),
    .bank_r_data_i       (bank_r_data),
    .bank_r_ready_o      (bank_r_ready)
  );

  ////////////////////////////////////////////////////////////////////
  // targets, one bank per region
  ////////////////////////////////////////////////////////////////////

  mem_bank #(
    .DEPTH (BANK0_WORDS)
  ) mem_bank0_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (bank_req[0]),
    .add_i     (bank_add[0]),
    .wen_i     (bank_wen[0]),
    .data_i    (bank_data[0]),
    .be_i      (bank_be[0]),
    .gnt_o     (bank_gnt[0]),
    .r_valid_o (bank_r_valid[0]),
    .r_data_o  (bank_r_data[0]),
    .r_ready_i (bank_r_ready[0])
  );

  mem_bank #(
    .DEPTH (BANK1_WORDS)
  ) mem_bank1_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (bank_req[1]),
    .add_i     (bank_add[1]),
    .wen_i     (bank_wen[1]),
    .data_i    (bank_data[1]),
    .be_i      (bank_be[1]),
    .gnt_o     (bank_gnt[1]),
    .r_valid_o (bank_r_valid[1]),
    .r_data_o  (bank_r_data[1]),
    .r_ready_i (bank_r_ready[1])
  );

endmodule

`default_nettype wire

/* verification/memmap_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_chk (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      clear_i,
  input logic                      req_i,
  input logic [memmap_pkg::AW-1:0] add_i,
  input logic                      wen_i,
  input logic [memmap_pkg::DW-1:0] data_i,
  input logic [memmap_pkg::BW-1:0] be_i,
  input logic                      gnt_i,
  input logic                      r_valid_i,
  input logic [memmap_pkg::DW-1:0] r_data_i,
  input logic                      r_opc_i,
  input logic                      r_ready_i
);

  // a request waiting for its grant keeps every field
  property req_held;
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
      (req_i && !gnt_i) |=>
        (req_i && $stable(add_i) && $stable(wen_i) && $stable(data_i) && $stable(be_i));
  endproperty

  // a raised response stays up with the same contents until it is taken
  property rsp_held;
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
      (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_data_i) && $stable(r_opc_i));
  endproperty

  a_req_held: assert property (req_held) else $error("request changed before its grant");
  a_rsp_held: assert property (rsp_held) else $error("response changed before it was taken");

endmodule

`default_nettype wire

/* verification/memmap_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_tb;
  import memmap_pkg::*;

  localparam int          NB_REGION = 2;
  localparam int          DEPTH [NB_REGION] = '{64, 32};
  localparam int unsigned TIMEOUT = 200;
  localparam int          N_RANDOM = 80;
  localparam logic        WR = 1'b0;
  localparam logic        RD = 1'b1;

  typedef logic [DW:0] val_t;

  typedef struct packed {
    logic          wen;
    logic [AW-1:0] add;
    logic [DW-1:0] data;
    logic [BW-1:0] be;
    logic [DW-1:0] exp_data;
    logic          exp_opc;
  } row_t;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic                         clear_i;
  logic [NB_REGION-1:0][AW-1:0] region_start;
  logic [NB_REGION-1:0][AW-1:0] region_end;
  logic                         req_i;
  logic [AW-1:0]                add_i;
  logic                         wen_i;
  logic [DW-1:0]                data_i;
  logic [BW-1:0]                be_i;
  logic                         gnt_o;
  logic                         r_valid_o;
  logic [DW-1:0]                r_data_o;
  logic                         r_opc_o;
  logic                         r_ready_i;

  logic        bp_mode = 1'b0;
  logic [DW-1:0] ref_mem [NB_REGION][64];
  row_t        rows [$];
  val_t        exp_q [$];
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned n_req = 0;
  int unsigned n_rsp = 0;

  always #4 clk_i = ~clk_i;

  memmap_top #(
    .NB_REGION   (NB_REGION),
    .BANK0_WORDS (DEPTH[0]),
    .BANK1_WORDS (DEPTH[1])
  ) memmap_top_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .clear_i             (clear_i),
    .region_start_addr_i (region_start),
    .region_end_addr_i   (region_end),
    .req_i               (req_i),
    .add_i               (add_i),
    .wen_i               (wen_i),
    .data_i              (data_i),
    .be_i                (be_i),
    .gnt_o               (gnt_o),
    .r_valid_o           (r_valid_o),
    .r_data_o            (r_data_o),
    .r_opc_o             (r_opc_o),
    .r_ready_i           (r_ready_i)
  );

  bind memmap_top memmap_chk memmap_chk_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .req_i     (req_i),
    .add_i     (add_i),
    .wen_i     (wen_i),
    .data_i    (data_i),
    .be_i      (be_i),
    .gnt_i     (gnt_o),
    .r_valid_i (r_valid_o),
    .r_data_i  (r_data_o),
    .r_opc_i   (r_opc_o),
    .r_ready_i (r_ready_i)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // the last region that holds the address wins, -1 when none does
  function automatic int find_region(input logic [AW-1:0] add);
    int rg;
    rg = -1;
    for (int i = 0; i < NB_REGION; i++) begin
      if ((add >= region_start[i]) && (add < region_end[i])) begin
        rg = i;
      end
    end
    return rg;
  endfunction

  task automatic predict(input row_t r_in, output val_t exp);
    int            rg;
    int            w;
    logic [DW-1:0] word;
    rg = find_region(r_in.add);
    if (rg < 0) begin
      exp = {OPC_ERR, {DW{1'b0}}};
    end else begin
      w    = int'((r_in.add - region_start[rg]) >> 2) % DEPTH[rg];
      word = ref_mem[rg][w];
      if (r_in.wen) begin
        exp = {OPC_OK, word};
      end else begin
        for (int b = 0; b < BW; b++) begin
          if (r_in.be[b]) begin
            word[8*b +: 8] = r_in.data[8*b +: 8];
          end
        end
        ref_mem[rg][w] = word;
        exp = {OPC_OK, {DW{1'b0}}};
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input val_t got, input val_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             n_checks, n_errors, n_req, n_rsp);
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t ns: %s", $time, why);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic wen, input logic [AW-1:0] add, input logic [DW-1:0] data,
                         input logic [BW-1:0] be, input logic [DW-1:0] exp_data,
                         input logic exp_opc);
    row_t r;
    r = '{wen, add, data, be, exp_data, exp_opc};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // region 0 words come back as written
    add_row(WR, 32'h0000_1000, 32'h1111_2222, 4'hf, 32'h0, OPC_OK);
    add_row(WR, 32'h0000_1004, 32'h3333_4444, 4'hf, 32'h0, OPC_OK);
    add_row(WR, 32'h0000_10fc, 32'hdead_beef, 4'hf, 32'h0, OPC_OK);
    add_row(RD, 32'h0000_1000, 32'h0, 4'h0, 32'h1111_2222, OPC_OK);
    add_row(RD, 32'h0000_1004, 32'h0, 4'h0, 32'h3333_4444, OPC_OK);
    add_row(RD, 32'h0000_10fc, 32'h0, 4'h0, 32'hdead_beef, OPC_OK);
    // region 1 offsets are relative to its own start
    add_row(WR, 32'h0000_2004, 32'h5555_6666, 4'hf, 32'h0, OPC_OK);
    add_row(WR, 32'h0000_207c, 32'h7777_8888, 4'hf, 32'h0, OPC_OK);
    add_row(RD, 32'h0000_2004, 32'h0, 4'h0, 32'h5555_6666, OPC_OK);
    add_row(RD, 32'h0000_1004, 32'h0, 4'h0, 32'h3333_4444, OPC_OK);
    add_row(RD, 32'h0000_207c, 32'h0, 4'h0, 32'h7777_8888, OPC_OK);
    // partial byte enables
    add_row(WR, 32'h0000_1008, 32'ha0b0_c0d0, 4'hf, 32'h0, OPC_OK);
    add_row(WR, 32'h0000_1008, 32'h1122_3344, 4'h5, 32'h0, OPC_OK);
    add_row(RD, 32'h0000_1008, 32'h0, 4'h0, 32'ha022_c044, OPC_OK);
    add_row(WR, 32'h0000_2010, 32'hffff_ffff, 4'hf, 32'h0, OPC_OK);
    add_row(WR, 32'h0000_2010, 32'h0000_0000, 4'h8, 32'h0, OPC_OK);
    add_row(RD, 32'h0000_2010, 32'h0, 4'h0, 32'h00ff_ffff, OPC_OK);
    // unmapped addresses, region ends are exclusive
    add_row(WR, 32'h0000_3000, 32'h1234_5678, 4'hf, 32'h0, OPC_ERR);
    add_row(RD, 32'h0000_3000, 32'h0, 4'h0, 32'h0, OPC_ERR);
    add_row(RD, 32'h0000_0ffc, 32'h0, 4'h0, 32'h0, OPC_ERR);
    add_row(WR, 32'h0000_1100, 32'hbad0_bad0, 4'hf, 32'h0, OPC_ERR);
    add_row(RD, 32'h0000_2080, 32'h0, 4'h0, 32'h0, OPC_ERR);
    add_row(RD, 32'h0000_1000, 32'h0, 4'h0, 32'h1111_2222, OPC_OK);
  endtask

  // called 1 ns after a rising edge and returns at the same point
  task automatic send(input row_t r_in, input val_t exp);
    int unsigned waited;
    req_i  = 1'b1;
    add_i  = r_in.add;
    wen_i  = r_in.wen;
    data_i = r_in.data;
    be_i   = r_in.be;
    waited = 0;
    @(negedge clk_i);
    while (gnt_o !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("a request was never granted");
      end
      @(negedge clk_i);
    end
    exp_q.push_back(exp);
    n_req++;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic drain();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("responses still missing at the end");
      end
      @(negedge clk_i);
    end
  endtask

  // drives r_ready_i and matches every response against the queue in order
  initial begin : monitor
    logic [31:0] rnd;
    int unsigned idle;
    logic        held;
    val_t        held_rsp;
    val_t        exp;
    r_ready_i = 1'b0;
    idle      = 0;
    held      = 1'b0;
    held_rsp  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      rnd       = $urandom;
      r_ready_i = bp_mode ? rnd[0] : 1'b1;
      @(negedge clk_i);
      if (held) begin
        check_value("held r_valid", val_t'(r_valid_o), val_t'(1'b1));
        check_value("held response", {r_opc_o, r_data_o}, held_rsp);
      end
      held     = rst_ni && r_valid_o && !r_ready_i;
      held_rsp = {r_opc_o, r_data_o};
      if (rst_ni && r_valid_o && r_ready_i) begin
        idle = 0;
        n_rsp++;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("error at %0t ns: response without a request", $time);
        end else begin
          exp = exp_q.pop_front();
          check_value("response", {r_opc_o, r_data_o}, exp);
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > TIMEOUT) begin
          abort_run("a pending request got no response");
        end
      end
    end
  end

  initial begin : main
    row_t        r;
    val_t        exp;
    logic [31:0] rnd;
    int unsigned seed_used;
    int          rg;
    int          w;
    seed_used       = $urandom(32'hef88_8aaa);
    clear_i         = 1'b0;
    req_i           = 1'b0;
    add_i           = '0;
    wen_i           = RD;
    data_i          = '0;
    be_i            = '0;
    region_start[0] = 32'h0000_1000;
    region_end[0]   = 32'h0000_1100;
    region_start[1] = 32'h0000_2000;
    region_end[1]   = 32'h0000_2080;
    rst_ni          = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("r_valid after reset", val_t'(r_valid_o), val_t'(1'b0));
    check_value("gnt after reset", val_t'(gnt_o), val_t'(1'b1));
    @(posedge clk_i);
    #1;

    // every mapped word starts from a pattern of its full address
    for (int i = 0; i < NB_REGION; i++) begin
      for (int k = 0; k < DEPTH[i]; k++) begin
        r.wen  = WR;
        r.add  = region_start[i] + 32'(4 * k);
        r.be   = '1;
        r.data = {r.add[15:0], r.add[31:16]} ^ (r.add << 7) ^ 32'h6b3c_91e5;
        predict(r, exp);
        send(r, exp);
      end
    end

    build_table();
    foreach (rows[k]) begin
      r = rows[k];
      predict(r, exp);
      send(r, {r.exp_opc, r.exp_data});
    end

    // random traffic while the response side stalls at random
    bp_mode = 1'b1;
    for (int k = 0; k < N_RANDOM; k++) begin
      rnd    = $urandom;
      r.wen  = rnd[0];
      r.be   = rnd[7:4];
      r.data = $urandom;
      if (rnd[3:1] == 3'b000) begin
        r.add = 32'h0000_3000 + 32'({rnd[15:8], 2'b00});
      end else begin
        rg    = rnd[16] ? 1 : 0;
        w     = int'(rnd[23:18]) % DEPTH[rg];
        r.add = region_start[rg] + 32'(4 * w);
      end
      predict(r, exp);
      send(r, exp);
    end
    drain();

    // a write still held in the slice is dropped by a clear pulse
    @(posedge clk_i);
    #1;
    req_i  = 1'b1;
    add_i  = 32'h0000_1000;
    wen_i  = WR;
    data_i = 32'h0bad_c1ea;
    be_i   = '1;
    @(negedge clk_i);
    check_value("gnt before clear", val_t'(gnt_o), val_t'(1'b1));
    @(posedge clk_i);
    #1;
    req_i   = 1'b0;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    @(negedge clk_i);
    check_value("r_valid after clear", val_t'(r_valid_o), val_t'(1'b0));
    check_value("gnt after clear", val_t'(gnt_o), val_t'(1'b1));
    @(posedge clk_i);
    #1;

    // read back every mapped word
    for (int i = 0; i < NB_REGION; i++) begin
      for (int k = 0; k < DEPTH[i]; k++) begin
        r.wen  = RD;
        r.add  = region_start[i] + 32'(4 * k);
        r.be   = '0;
        r.data = '0;
        predict(r, exp);
        send(r, exp);
      end
    end

    drain();
    check_value("response count", val_t'(n_rsp), val_t'(n_req));
    print_counts();
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/memmap_pkg.sv
design/req_slice.sv
memmap_demux/memmap_demux.sv
design/mem_bank.sv
design/memmap_top.sv
verification/memmap_chk.sv
verification/memmap_tb.sv

/* run.sh */
#!/bin/sh
# builds the simulation with Verilator, runs it and inspects the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module memmap_tb --Mdir "$BUILD_DIR" -o memmap_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/memmap_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0
